/* src/nes_mem_pkg.sv */
// Widths, PPU register numbers and memory sizes shared by all decoder RTL; import wherever needed
package nes_mem_pkg;

	////////////////////////////////////////////////////////////
	// Bus and index types
	////////////////////////////////////////////////////////////

	// One data byte, CPU or PPU side
	typedef logic [7:0]  byte_t;
	// CPU address bus, also the raw VRAM pointer
	typedef logic [15:0] cpu_addr_t;
	// Physical video RAM index after folding
	typedef logic [13:0] vram_addr_t;
	typedef logic [7:0]  oam_addr_t;
	typedef logic [10:0] ram_addr_t;
	typedef logic [2:0]  reg_idx_t;

	// Decode result of the first stage
	typedef enum logic [2:0] {
		REGION_RAM,
		REGION_PPU_REG,
		REGION_JOY1,
		REGION_JOY2,
		REGION_NONE
	} cpu_region_e;

	////////////////////////////////////////////////////////////
	// PPU register numbers, low 3 address bits
	////////////////////////////////////////////////////////////
	localparam reg_idx_t REG_CTRL1     = 3'd0;
	localparam reg_idx_t REG_CTRL2     = 3'd1;
	localparam reg_idx_t REG_STATUS    = 3'd2;
	localparam reg_idx_t REG_OAM_ADDR  = 3'd3;
	localparam reg_idx_t REG_OAM_DATA  = 3'd4;
	localparam reg_idx_t REG_SCROLL    = 3'd5;
	localparam reg_idx_t REG_VRAM_ADDR = 3'd6;
	localparam reg_idx_t REG_VRAM_DATA = 3'd7;

	// Memory sizes in bytes
	localparam int WORK_RAM_DEPTH = 2048;
	localparam int VRAM_DEPTH     = 16384;
	localparam int OAM_DEPTH      = 256;

	// Palette start; CPU reads from here up skip the read buffer
	localparam vram_addr_t PALETTE_BASE = 14'h3F00;
	localparam int CTRL1_INC32_BIT = 2;
	// Joypad byte addresses
	localparam cpu_addr_t JOY1_ADDR = 16'h4016;
	localparam cpu_addr_t JOY2_ADDR = 16'h4017;

endpackage

/* src/cpu_addr_map.sv */
// First decoder stage, purely combinational; sorts a CPU address into its region and folds mirrors
`timescale 1ns/1ps

module cpu_addr_map (
	input  nes_mem_pkg::cpu_addr_t   cpu_addr,
	output nes_mem_pkg::cpu_region_e region,
	output nes_mem_pkg::reg_idx_t    reg_idx,
	output nes_mem_pkg::ram_addr_t   ram_addr
);
	import nes_mem_pkg::*;

	////////////////////////////////////////////////////////////
	// Region decode
	////////////////////////////////////////////////////////////

	always_comb begin
		// 0x0000-0x1FFF, four copies of 2 KB
		if (cpu_addr[15:13] == 3'b000) begin
			region = REGION_RAM;
		end else if (cpu_addr[15:13] == 3'b001) begin
			// 0x2000-0x3FFF, eight registers repeated
			region = REGION_PPU_REG;
		end else if (cpu_addr == JOY1_ADDR) begin
			region = REGION_JOY1;
		end else if (cpu_addr == JOY2_ADDR) begin
			region = REGION_JOY2;
		end else begin
			// Cartridge space etc, reads as zero
			region = REGION_NONE;
		end
	end

	// Mirror folding
	assign ram_addr = cpu_addr[10:0];
	// Only looked at in the register region
	assign reg_idx = cpu_addr[2:0];

endmodule

/* src/vram_addr_map.sv */
// Video address folding, shared by the CPU and PPU sides; maps a 16-bit pointer to a physical VRAM index
`timescale 1ns/1ps

module vram_addr_map (
	input  nes_mem_pkg::cpu_addr_t  addr,
	input  logic                    h_mirror,
	input  logic                    v_mirror,
	output nes_mem_pkg::vram_addr_t phys
);
	import nes_mem_pkg::*;

	vram_addr_t wrapped;
	logic       is_palette;
	logic       is_nametable;

	// 16 KB space, top two bits dropped
	assign wrapped = addr[13:0];
	assign is_palette = (wrapped >= PALETTE_BASE);
	// 0x2000-0x3EFF
	assign is_nametable = wrapped[13] && !is_palette;

	////////////////////////////////////////////////////////////
	// Mirror folding
	////////////////////////////////////////////////////////////

	always_comb begin
		phys = wrapped;
		if (is_palette) begin
			// 32 palette bytes repeat up to 0x3FFF
			phys = PALETTE_BASE | vram_addr_t'(wrapped[4:0]);
		end else if (is_nametable) begin
			// 0x3000-0x3EFF is a copy of 0x2000
			phys[12] = 1'b0;
			if (v_mirror) begin
				// Left and right tables shared
				phys[11] = 1'b0;
			end else if (h_mirror) begin
				// Top and bottom tables shared
				phys[10] = wrapped[11];
				phys[11] = 1'b0;
			end
			// Neither set, four-screen
		end
	end

	// Only one mirroring mode at a time
	mirror_mode_a: assert #0 (!(h_mirror && v_mirror))
		else $error("h_mirror and v_mirror both set");

endmodule

/* src/dual_port_ram.sv */
// Byte RAM; port A writes on the clock and reads combinationally, port B is a combinational read
`timescale 1ns/1ps

module dual_port_ram #(
	parameter int depth      = 256,
	parameter int addr_width = 8
) (
	input  logic                    clk,
	input  logic                    we,
	input  logic [addr_width-1:0]   waddr,
	input  nes_mem_pkg::byte_t      wdata,
	output nes_mem_pkg::byte_t      rdata_a,
	input  logic [addr_width-1:0]   raddr_b,
	output nes_mem_pkg::byte_t      rdata_b
);
	import nes_mem_pkg::*;

	// Contents undefined after reset
	byte_t mem [depth];

	// Port A write
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Both reads without latency
	assign rdata_a = mem[waddr];
	assign rdata_b = mem[raddr_b];

endmodule

/* src/ppu_reg_file.sv */
// Second decoder stage; PPU control, scroll, OAM and VRAM pointers, write toggle and VRAM read buffer
`timescale 1ns/1ps

module ppu_reg_file (
	input  logic                     clk,
	input  logic                     rst,
	input  nes_mem_pkg::cpu_region_e region,
	input  nes_mem_pkg::reg_idx_t    reg_idx,
	input  nes_mem_pkg::byte_t       cpu_data_in,
	input  logic                     cpu_write_en,
	input  logic                     cpu_read_en,
	input  nes_mem_pkg::vram_addr_t  vram_cpu_phys,
	input  nes_mem_pkg::byte_t       vram_cpu_rdata,
	input  nes_mem_pkg::byte_t       oam_cpu_rdata,
	input  nes_mem_pkg::byte_t       ppu_status,
	output nes_mem_pkg::byte_t       ppu_ctrl1,
	output nes_mem_pkg::byte_t       ppu_ctrl2,
	output logic [15:0]              ppu_scroll,
	output logic                     ppu_status_read,
	output nes_mem_pkg::cpu_addr_t   vram_cpu_addr,
	output logic                     vram_cpu_we,
	output nes_mem_pkg::oam_addr_t   oam_cpu_addr,
	output logic                     oam_cpu_we,
	output nes_mem_pkg::byte_t       reg_read_data
);
	import nes_mem_pkg::*;

	logic      reg_wr;
	logic      reg_rd;
	logic      vram_access;
	logic      oam_access;
	logic      buffered;
	logic      write_toggle;
	byte_t     read_buf;
	cpu_addr_t vram_step;

	////////////////////////////////////////////////////////////
	// Access decode
	////////////////////////////////////////////////////////////

	assign reg_wr = (region == REGION_PPU_REG) && cpu_write_en;
	assign reg_rd = (region == REGION_PPU_REG) && cpu_read_en;

	// PPU clears vblank on this pulse
	assign ppu_status_read = reg_rd && (reg_idx == REG_STATUS);
	assign vram_cpu_we = reg_wr && (reg_idx == REG_VRAM_DATA);
	assign oam_cpu_we = reg_wr && (reg_idx == REG_OAM_DATA);

	// Data port accesses, read or write, advance the pointers
	assign vram_access = (reg_wr || reg_rd) && (reg_idx == REG_VRAM_DATA);
	assign oam_access = (reg_wr || reg_rd) && (reg_idx == REG_OAM_DATA);

	// Below palette space reads go through the buffer
	assign buffered = (vram_cpu_phys < PALETTE_BASE);
	// 32 steps one nametable row down
	assign vram_step = ppu_ctrl1[CTRL1_INC32_BIT] ? 16'd32 : 16'd1;

	////////////////////////////////////////////////////////////
	// Control, scroll and write toggle
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ppu_ctrl1 <= '0;
			ppu_ctrl2 <= '0;
			ppu_scroll <= '0;
			write_toggle <= 1'b0;
		end else if (ppu_status_read) begin
			write_toggle <= 1'b0;
		end else if (reg_wr) begin
			case (reg_idx)
				REG_CTRL1: ppu_ctrl1 <= cpu_data_in;
				REG_CTRL2: ppu_ctrl2 <= cpu_data_in;
				REG_SCROLL: begin
					// X first, Y second
					if (write_toggle) begin
						ppu_scroll[15:8] <= cpu_data_in;
					end else begin
						ppu_scroll[7:0] <= cpu_data_in;
					end
					write_toggle <= !write_toggle;
				end
				REG_VRAM_ADDR: write_toggle <= !write_toggle;
				default: ;
			endcase
		end
	end

	// VRAM and OAM pointers
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vram_cpu_addr <= '0;
			oam_cpu_addr <= '0;
		end else begin
			// High byte on the first write, low byte on the second
			if (reg_wr && reg_idx == REG_VRAM_ADDR) begin
				if (write_toggle) begin
					vram_cpu_addr[7:0] <= cpu_data_in;
				end else begin
					vram_cpu_addr[15:8] <= cpu_data_in;
				end
			end else if (vram_access) begin
				vram_cpu_addr <= vram_cpu_addr + vram_step;
			end
			if (reg_wr && reg_idx == REG_OAM_ADDR) begin
				oam_cpu_addr <= cpu_data_in;
			end else if (oam_access) begin
				oam_cpu_addr <= oam_cpu_addr + 8'd1;
			end
		end
	end

	// Read buffer, loaded with the byte under the pointer
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			read_buf <= '0;
		end else if (vram_access && reg_rd && buffered) begin
			read_buf <= vram_cpu_rdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Register read value
	////////////////////////////////////////////////////////////

	always_comb begin
		case (reg_idx)
			REG_CTRL1:     reg_read_data = ppu_ctrl1;
			REG_CTRL2:     reg_read_data = ppu_ctrl2;
			REG_STATUS:    reg_read_data = ppu_status;
			REG_OAM_ADDR:  reg_read_data = oam_cpu_addr;
			REG_OAM_DATA:  reg_read_data = oam_cpu_rdata;
			REG_SCROLL:    reg_read_data = ppu_scroll[7:0];
			REG_VRAM_ADDR: reg_read_data = vram_cpu_addr[7:0];
			// Stale byte below palette, live byte above
			default:       reg_read_data = buffered ? read_buf : vram_cpu_rdata;
		endcase
	end

	// Status read has priority over writes in the toggle logic, so the CPU
	// must never strobe read and write in the same cycle
	strobe_excl_a: assert property (@(posedge clk) disable iff (!rst)
		!(cpu_write_en && cpu_read_en));

endmodule

/* src/mem_decode.sv */
// Top of the console memory decoder; CPU bus in, PPU registers and video/sprite RAM ports out
`timescale 1ns/1ps

module mem_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  nes_mem_pkg::cpu_addr_t cpu_addr,
	input  nes_mem_pkg::byte_t     cpu_data_in,
	output nes_mem_pkg::byte_t     cpu_data_out,
	input  logic                   cpu_write_en,
	input  logic                   cpu_read_en,
	output nes_mem_pkg::byte_t     ppu_ctrl1,
	output nes_mem_pkg::byte_t     ppu_ctrl2,
	input  nes_mem_pkg::byte_t     ppu_status,
	output logic [15:0]            ppu_scroll,
	output logic                   ppu_status_read,
	input  nes_mem_pkg::cpu_addr_t vram_ppu_addr,
	output nes_mem_pkg::byte_t     vram_ppu_data,
	input  nes_mem_pkg::oam_addr_t spram_ppu_addr,
	output nes_mem_pkg::byte_t     spram_ppu_data,
	input  nes_mem_pkg::byte_t     joycon_1,
	input  nes_mem_pkg::byte_t     joycon_2,
	input  logic                   h_mirror,
	input  logic                   v_mirror
);
	import nes_mem_pkg::*;

	cpu_region_e region;
	reg_idx_t    reg_idx;
	ram_addr_t   ram_addr;
	byte_t       ram_rdata;
	logic        ram_we;
	cpu_addr_t   vram_cpu_addr;
	vram_addr_t  vram_cpu_phys;
	vram_addr_t  vram_ppu_phys;
	logic        vram_cpu_we;
	byte_t       vram_cpu_rdata;
	oam_addr_t   oam_cpu_addr;
	logic        oam_cpu_we;
	byte_t       oam_cpu_rdata;
	byte_t       reg_read_data;

	////////////////////////////////////////////////////////////
	// Stage 1, address map
	////////////////////////////////////////////////////////////
	cpu_addr_map cpu_addr_map_i (
		.cpu_addr (cpu_addr),
		.region   (region),
		.reg_idx  (reg_idx),
		.ram_addr (ram_addr)
	);

	// Work RAM, port B not needed
	assign ram_we = cpu_write_en && (region == REGION_RAM);

	dual_port_ram #(
		.depth      (WORK_RAM_DEPTH),
		.addr_width ($clog2(WORK_RAM_DEPTH))
	) work_ram_i (
		.clk     (clk),
		.we      (ram_we),
		.waddr   (ram_addr),
		.wdata   (cpu_data_in),
		.rdata_a (ram_rdata),
		.raddr_b (ram_addr),
		.rdata_b ()
	);

	////////////////////////////////////////////////////////////
	// Stage 2, registers and video memories
	////////////////////////////////////////////////////////////
	ppu_reg_file ppu_reg_file_i (
		.clk             (clk),
		.rst             (rst),
		.region          (region),
		.reg_idx         (reg_idx),
		.cpu_data_in     (cpu_data_in),
		.cpu_write_en    (cpu_write_en),
		.cpu_read_en     (cpu_read_en),
		.vram_cpu_phys   (vram_cpu_phys),
		.vram_cpu_rdata  (vram_cpu_rdata),
		.oam_cpu_rdata   (oam_cpu_rdata),
		.ppu_status      (ppu_status),
		.ppu_ctrl1       (ppu_ctrl1),
		.ppu_ctrl2       (ppu_ctrl2),
		.ppu_scroll      (ppu_scroll),
		.ppu_status_read (ppu_status_read),
		.vram_cpu_addr   (vram_cpu_addr),
		.vram_cpu_we     (vram_cpu_we),
		.oam_cpu_addr    (oam_cpu_addr),
		.oam_cpu_we      (oam_cpu_we),
		.reg_read_data   (reg_read_data)
	);

	// Same folding on both sides of VRAM
	vram_addr_map vram_cpu_map_i (
		.addr     (vram_cpu_addr),
		.h_mirror (h_mirror),
		.v_mirror (v_mirror),
		.phys     (vram_cpu_phys)
	);

	vram_addr_map vram_ppu_map_i (
		.addr     (vram_ppu_addr),
		.h_mirror (h_mirror),
		.v_mirror (v_mirror),
		.phys     (vram_ppu_phys)
	);

	// CPU on port A, PPU fetches on port B
	dual_port_ram #(
		.depth      (VRAM_DEPTH),
		.addr_width ($clog2(VRAM_DEPTH))
	) vram_i (
		.clk     (clk),
		.we      (vram_cpu_we),
		.waddr   (vram_cpu_phys),
		.wdata   (cpu_data_in),
		.rdata_a (vram_cpu_rdata),
		.raddr_b (vram_ppu_phys),
		.rdata_b (vram_ppu_data)
	);

	dual_port_ram #(
		.depth      (OAM_DEPTH),
		.addr_width ($clog2(OAM_DEPTH))
	) spram_i (
		.clk     (clk),
		.we      (oam_cpu_we),
		.waddr   (oam_cpu_addr),
		.wdata   (cpu_data_in),
		.rdata_a (oam_cpu_rdata),
		.raddr_b (spram_ppu_addr),
		.rdata_b (spram_ppu_data)
	);

	////////////////////////////////////////////////////////////
	// Stage 3, read return
	////////////////////////////////////////////////////////////
	always_comb begin
		case (region)
			REGION_RAM:     cpu_data_out = ram_rdata;
			REGION_PPU_REG: cpu_data_out = reg_read_data;
			REGION_JOY1:    cpu_data_out = joycon_1;
			REGION_JOY2:    cpu_data_out = joycon_2;
			// Unmapped space
			default:        cpu_data_out = '0;
		endcase
	end

endmodule

/* sim/mem_decode_tb.sv */
// Self-checking testbench for the memory decoder; drives CPU and PPU ports, checks by SVA against a model
`timescale 1ns/1ps

module mem_decode_tb;
	import nes_mem_pkg::*;

	// Roughly 130 CPU accesses and PPU peeks at two cycles each plus reset, near 300 cycles
	localparam int CYCLE_LIMIT = 4000;

	logic        clk;
	logic        rst;
	cpu_addr_t   cpu_addr;
	byte_t       cpu_data_in;
	byte_t       cpu_data_out;
	logic        cpu_write_en;
	logic        cpu_read_en;
	byte_t       ppu_ctrl1;
	byte_t       ppu_ctrl2;
	byte_t       ppu_status;
	logic [15:0] ppu_scroll;
	logic        ppu_status_read;
	cpu_addr_t   vram_ppu_addr;
	byte_t       vram_ppu_data;
	oam_addr_t   spram_ppu_addr;
	byte_t       spram_ppu_data;
	byte_t       joycon_1;
	byte_t       joycon_2;
	logic        h_mirror;
	logic        v_mirror;

	////////////////////////////////////////////////////////////
	// Reference model state
	////////////////////////////////////////////////////////////
	byte_t       ram_m [WORK_RAM_DEPTH];
	byte_t       vram_m [VRAM_DEPTH];
	byte_t       oam_m [OAM_DEPTH];
	byte_t       m_ctrl1 = '0;
	byte_t       m_ctrl2 = '0;
	byte_t       m_rbuf = '0;
	byte_t       m_oaddr = '0;
	logic [15:0] m_scroll = '0;
	logic [15:0] m_vaddr = '0;
	logic        m_toggle = 1'b0;
	// Expected values, set together with the stimulus
	byte_t       exp_read = '0;
	byte_t       exp_vram = '0;
	byte_t       exp_spram = '0;
	logic        vram_check = 1'b0;
	logic        spram_check = 1'b0;
	int          errors = 0;
	int          tests = 0;
	int          accesses = 0;
	int          cycles = 0;
	integer      seed = 62189;

	mem_decode mem_decode_i (
		.clk             (clk),
		.rst             (rst),
		.cpu_addr        (cpu_addr),
		.cpu_data_in     (cpu_data_in),
		.cpu_data_out    (cpu_data_out),
		.cpu_write_en    (cpu_write_en),
		.cpu_read_en     (cpu_read_en),
		.ppu_ctrl1       (ppu_ctrl1),
		.ppu_ctrl2       (ppu_ctrl2),
		.ppu_status      (ppu_status),
		.ppu_scroll      (ppu_scroll),
		.ppu_status_read (ppu_status_read),
		.vram_ppu_addr   (vram_ppu_addr),
		.vram_ppu_data   (vram_ppu_data),
		.spram_ppu_addr  (spram_ppu_addr),
		.spram_ppu_data  (spram_ppu_data),
		.joycon_1        (joycon_1),
		.joycon_2        (joycon_2),
		.h_mirror        (h_mirror),
		.v_mirror        (v_mirror)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run length guard
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic log_mismatch(input string msg);
		errors++;
		$display("** Error at %0t: %s", $time, msg);
	endtask

	function automatic byte_t rand_byte();
		return byte_t'($random(seed));
	endfunction

	////////////////////////////////////////////////////////////
	// Model rules
	////////////////////////////////////////////////////////////

	// Physical VRAM index, worked out per nametable quadrant
	function automatic vram_addr_t phys_index(input cpu_addr_t a);
		int w;
		int quad;
		w = a % 16384;
		if (w >= 'h3F00) return vram_addr_t'('h3F00 + w % 32);
		if (w < 'h2000) return vram_addr_t'(w);
		quad = ((w - 'h2000) / 'h400) % 4;
		// Vertical keeps left/right, horizontal keeps top/bottom
		if (v_mirror) quad = quad % 2;
		else if (h_mirror) quad = quad / 2;
		return vram_addr_t'('h2000 + quad * 'h400 + w % 'h400);
	endfunction

	function automatic cpu_addr_t vram_stride();
		return m_ctrl1[CTRL1_INC32_BIT] ? 16'd32 : 16'd1;
	endfunction

	function automatic byte_t expect_read(input cpu_addr_t a);
		vram_addr_t p;
		p = phys_index(m_vaddr);
		if (a < 16'h2000) return ram_m[a % WORK_RAM_DEPTH];
		if (a < 16'h4000) begin
			case (a % 8)
				0: return m_ctrl1;
				1: return m_ctrl2;
				2: return ppu_status;
				3: return m_oaddr;
				4: return oam_m[m_oaddr];
				5: return m_scroll[7:0];
				6: return m_vaddr[7:0];
				// Buffered below palette space
				default: return (p < 14'h3F00) ? m_rbuf : vram_m[p];
			endcase
		end
		if (a == 16'h4016) return joycon_1;
		if (a == 16'h4017) return joycon_2;
		return 8'h00;
	endfunction

	task automatic model_write(input cpu_addr_t a, input byte_t d);
		vram_addr_t p;
		p = phys_index(m_vaddr);
		if (a < 16'h2000) begin
			ram_m[a % WORK_RAM_DEPTH] = d;
		end else if (a < 16'h4000) begin
			case (a % 8)
				0: m_ctrl1 = d;
				1: m_ctrl2 = d;
				3: m_oaddr = d;
				4: begin
					oam_m[m_oaddr] = d;
					m_oaddr = m_oaddr + 8'd1;
				end
				5: begin
					if (m_toggle) m_scroll[15:8] = d;
					else m_scroll[7:0] = d;
					m_toggle = !m_toggle;
				end
				6: begin
					// High byte first
					if (m_toggle) m_vaddr[7:0] = d;
					else m_vaddr[15:8] = d;
					m_toggle = !m_toggle;
				end
				7: begin
					vram_m[p] = d;
					m_vaddr = m_vaddr + vram_stride();
				end
				default: ;
			endcase
		end
	endtask

	task automatic model_read(input cpu_addr_t a);
		vram_addr_t p;
		p = phys_index(m_vaddr);
		if (a >= 16'h2000 && a < 16'h4000) begin
			case (a % 8)
				2: m_toggle = 1'b0;
				4: m_oaddr = m_oaddr + 8'd1;
				7: begin
					if (p < 14'h3F00) m_rbuf = vram_m[p];
					m_vaddr = m_vaddr + vram_stride();
				end
				default: ;
			endcase
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus tasks, strobe high for one cycle from a falling edge
	////////////////////////////////////////////////////////////
	task automatic cpu_write(input cpu_addr_t a, input byte_t d);
		@(negedge clk);
		cpu_addr = a;
		cpu_data_in = d;
		cpu_write_en = 1'b1;
		@(negedge clk);
		cpu_write_en = 1'b0;
		model_write(a, d);
		accesses++;
	endtask

	task automatic cpu_read(input cpu_addr_t a);
		@(negedge clk);
		cpu_addr = a;
		exp_read = expect_read(a);
		cpu_read_en = 1'b1;
		@(negedge clk);
		cpu_read_en = 1'b0;
		model_read(a);
		accesses++;
	endtask

	// Status read first, so the toggle is clear
	task automatic set_vram_addr(input cpu_addr_t a);
		cpu_read(16'h2002);
		cpu_write(16'h2006, a[15:8]);
		cpu_write(16'h2006, a[7:0]);
	endtask

	task automatic check_vram_port(input cpu_addr_t a);
		@(negedge clk);
		vram_ppu_addr = a;
		exp_vram = vram_m[phys_index(a)];
		vram_check = 1'b1;
		@(negedge clk);
		vram_check = 1'b0;
	endtask

	task automatic check_oam_port(input oam_addr_t a);
		@(negedge clk);
		spram_ppu_addr = a;
		exp_spram = oam_m[a];
		spram_check = 1'b1;
		@(negedge clk);
		spram_check = 1'b0;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("Test %0d (%s) finished, %0d errors so far", tests, name, errors);
	endtask

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	read_data_a: assert property (@(posedge clk) disable iff (!rst)
		cpu_read_en |-> cpu_data_out == exp_read)
		else log_mismatch($sformatf("read of %h returned %h, expected %h",
			$sampled(cpu_addr), $sampled(cpu_data_out), $sampled(exp_read)));

	// Mirrors of the status register count too
	status_pulse_a: assert property (@(posedge clk) disable iff (!rst)
		ppu_status_read == (cpu_read_en && cpu_addr >= 16'h2000 && cpu_addr < 16'h4000 &&
		cpu_addr % 8 == 2))
		else log_mismatch($sformatf("status pulse %b at address %h",
			$sampled(ppu_status_read), $sampled(cpu_addr)));

	regs_a: assert property (@(posedge clk) disable iff (!rst)
		ppu_ctrl1 == m_ctrl1 && ppu_ctrl2 == m_ctrl2 && ppu_scroll == m_scroll)
		else log_mismatch($sformatf("ctrl1 %h ctrl2 %h scroll %h, expected %h %h %h",
			$sampled(ppu_ctrl1), $sampled(ppu_ctrl2), $sampled(ppu_scroll),
			$sampled(m_ctrl1), $sampled(m_ctrl2), $sampled(m_scroll)));

	vram_port_a: assert property (@(posedge clk) disable iff (!rst)
		vram_check |-> vram_ppu_data == exp_vram)
		else log_mismatch($sformatf("PPU VRAM read of %h returned %h, expected %h",
			$sampled(vram_ppu_addr), $sampled(vram_ppu_data), $sampled(exp_vram)));

	spram_port_a: assert property (@(posedge clk) disable iff (!rst)
		spram_check |-> spram_ppu_data == exp_spram)
		else log_mismatch($sformatf("PPU sprite read of %h returned %h, expected %h",
			$sampled(spram_ppu_addr), $sampled(spram_ppu_data), $sampled(exp_spram)));

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////
	task automatic test_work_ram();
		cpu_addr_t a;
		int i;
		for (i = 0; i < 4; i++) begin
			a = cpu_addr_t'($random(seed)) & 16'h07FF;
			cpu_write(a, rand_byte());
			cpu_read(a + 16'h0800);
			cpu_read(a + 16'h1800);
		end
		// Cartridge space not decoded
		cpu_read(16'h5000);
		finish_test("work RAM mirrors");
	endtask

	task automatic test_ctrl_status();
		cpu_write(16'h2000, rand_byte());
		cpu_write(16'h2009, rand_byte());
		cpu_read(16'h2000);
		cpu_read(16'h2009);
		cpu_read(16'h2002);
		cpu_read(16'h3FFA);
		cpu_read(16'h4016);
		cpu_read(16'h4017);
		finish_test("control, status and joypads");
	endtask

	task automatic test_scroll_toggle();
		cpu_read(16'h2002);
		cpu_write(16'h2005, rand_byte());
		cpu_write(16'h2005, rand_byte());
		// Half a pair, then the status read drops it
		cpu_write(16'h2005, rand_byte());
		cpu_read(16'h2002);
		cpu_write(16'h200D, rand_byte());
		finish_test("scroll and write toggle");
	endtask

	task automatic test_vram_cpu();
		int i;
		cpu_write(16'h2000, 8'h00);
		set_vram_addr(16'h2100);
		for (i = 0; i < 8; i++) cpu_write(16'h2007, rand_byte());
		// One row per write
		cpu_write(16'h2000, 8'h04);
		set_vram_addr(16'h2200);
		for (i = 0; i < 6; i++) cpu_write(16'h2007, rand_byte());
		// First read gives the stale buffer
		cpu_write(16'h2000, 8'h00);
		set_vram_addr(16'h2100);
		for (i = 0; i < 8; i++) cpu_read(16'h2007);
		cpu_write(16'h2000, 8'h04);
		set_vram_addr(16'h2200);
		for (i = 0; i < 6; i++) cpu_read(16'h2007);
		// Palette bytes come back at once
		cpu_write(16'h2000, 8'h00);
		set_vram_addr(16'h3F00);
		for (i = 0; i < 4; i++) cpu_write(16'h2007, rand_byte());
		set_vram_addr(16'h3F00);
		for (i = 0; i < 4; i++) cpu_read(16'h2007);
		finish_test("VRAM through the CPU");
	endtask

	task automatic test_oam();
		oam_addr_t base;
		int i;
		base = rand_byte();
		cpu_write(16'h2003, base);
		for (i = 0; i < 8; i++) cpu_write(16'h2004, rand_byte());
		for (i = 0; i < 8; i++) check_oam_port(oam_addr_t'(base + i));
		finish_test("sprite RAM");
	endtask

	task automatic test_mirroring();
		@(negedge clk);
		h_mirror = 1'b0;
		v_mirror = 1'b1;
		set_vram_addr(16'h2400);
		cpu_write(16'h2007, rand_byte());
		check_vram_port(16'h2400);
		check_vram_port(16'h2C00);
		@(negedge clk);
		v_mirror = 1'b0;
		h_mirror = 1'b1;
		set_vram_addr(16'h2000);
		cpu_write(16'h2007, rand_byte());
		check_vram_port(16'h2000);
		check_vram_port(16'h2400);
		set_vram_addr(16'h3F10);
		cpu_write(16'h2007, rand_byte());
		check_vram_port(16'h3F10);
		check_vram_port(16'h3F30);
		@(negedge clk);
		h_mirror = 1'b0;
		finish_test("PPU port mirroring");
	endtask

	initial begin
		rst = 1'b0;
		cpu_addr = '0;
		cpu_data_in = '0;
		cpu_write_en = 1'b0;
		cpu_read_en = 1'b0;
		vram_ppu_addr = '0;
		spram_ppu_addr = '0;
		h_mirror = 1'b0;
		v_mirror = 1'b0;
		ppu_status = rand_byte();
		joycon_1 = rand_byte();
		joycon_2 = rand_byte();
		repeat (16) @(negedge clk);
		rst = 1'b1;
		test_work_ram();
		test_ctrl_status();
		test_scroll_toggle();
		test_vram_cpu();
		test_oam();
		test_mirroring();
		@(negedge clk);
		$display("Summary: %0d tests, %0d CPU accesses, %0d errors", tests, accesses, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* sources.f */
src/nes_mem_pkg.sv
src/cpu_addr_map.sv
src/vram_addr_map.sv
src/dual_port_ram.sv
src/ppu_reg_file.sv
src/mem_decode.sv
sim/mem_decode_tb.sv
